// File: sources.f
design/lsu_pkg.sv
design/lu_issue_buffer.sv
design/su_issue_fifo.sv
design/reg_file_wb_log.sv
design/lsu_issue.sv
design/lsu_issue_top.sv
bench/lsu_issue_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= lsu_issue_tb
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -j 0 -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/lsu_issue_tb.sv
// Load/store issue testbench
`timescale 1ns/1ps

module lsu_issue_tb;

	localparam int N_OPS = 400;
	// 40 cycles per op plus slack
	localparam int LIMIT = 40 * N_OPS + 200;
	localparam int DRAIN_MAX = 2000;

	// DUT inputs start idle, reset asserted
	logic              CLK = 1'b0;
	logic              arst_n = 1'b0;
	logic              lu_push = 1'b0;
	logic              su_push = 1'b0;
	logic              alloc_valid = 1'b0;
	logic              wb_valid = 1'b0;
	logic              commit_ready = 1'b0;
	logic              lu_exe_ready = 1'b0;
	logic              su_exe_ready = 1'b0;
	lsu_pkg::lu_uop_t  lu_push_uop = '0;
	lsu_pkg::su_uop_t  su_push_uop = '0;
	lsu_pkg::phy_tag_t alloc_tag = '0;
	lsu_pkg::phy_tag_t wb_tag = '0;
	lsu_pkg::xlen_t    wb_data = '0;
	logic              lu_full;
	logic              su_full;
	logic              lu_exe_valid;
	logic              su_exe_valid;
	lsu_pkg::lu_exe_t  lu_exe;
	lsu_pkg::su_exe_t  su_exe;

	// Register file copy
	lsu_pkg::xlen_t    reg_val [64] = '{default: '0};
	logic [63:0]       reg_rdy = '1;
	// Log as it stood before the last rising edge
	logic [63:0]       rdy_snap = '1;
	// Waiting loads by rd, stores in push order
	logic [63:0]       ld_pend = '0;
	lsu_pkg::lu_uop_t  ld_uop [64];
	int                ld_kind [64];
	lsu_pkg::su_uop_t  st_q [$];
	int                st_kind_q [$];
	// Tags still owed a writeback
	lsu_pkg::phy_tag_t busy_q [$];
	lsu_pkg::phy_tag_t last_rd = '0;
	logic [31:0]       lfsr = 32'h12b4_30c7;
	int                dispatched = 0;
	// Levels seen or driven at the previous falling edge
	logic              prev_lu_v = 1'b0;
	logic              prev_lu_r = 1'b0;
	logic              prev_su_v = 1'b0;
	logic              prev_su_r = 1'b0;
	logic              prev_commit = 1'b0;
	lsu_pkg::lu_exe_t  prev_lu;
	lsu_pkg::su_exe_t  prev_su;

	lsu_issue_top #(.LU_DEPTH(8), .SU_DEPTH(4)) DUT (.*);

	always #5 CLK = ~CLK;

	// Galois LFSR, right shift
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
	endfunction

	// One step per bit taken
	task automatic take_bits(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[62:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "%s", why);
	endtask

	task automatic check_value(input string name, input logic [131:0] expected,
			input logic [131:0] actual);
		if (expected !== actual) begin
			abort_run($sformatf("Error %s expected %h actual %h", name, expected, actual));
		end
	endtask

	// Tag can be renamed again only once no waiting op names it
	function automatic logic tag_in_use(input lsu_pkg::phy_tag_t t);
		logic hit;
		hit = ld_pend[t];
		for (int i = 0; i < 64; i++) begin
			hit |= ld_pend[i] && (ld_uop[i].rs1 == t);
		end
		foreach (st_q[i]) begin
			hit |= (st_q[i].rs1 == t) || (st_q[i].rs2 == t);
		end
		return hit;
	endfunction

	// Outputs as loaded at the last rising edge
	task automatic observe();
		lsu_pkg::lu_uop_t u;
		lsu_pkg::su_uop_t s;
		if (prev_lu_v && !prev_lu_r) begin
			// Stalled load packet
			check_value("load hold valid", 1, lu_exe_valid);
			check_value("load hold packet", prev_lu, lu_exe);
		end else if (lu_exe_valid) begin
			check_value("load register enable", 1, prev_lu_r);
			check_value("load rd pending", 1, ld_pend[lu_exe.rd]);
			u = ld_uop[lu_exe.rd];
			// Base had to be written back before the issue edge
			check_value("load rs1 ready", 1, rdy_snap[u.rs1]);
		end
		if (prev_su_v && !prev_su_r) begin
			check_value("store hold valid", 1, su_exe_valid);
			check_value("store hold packet", prev_su, su_exe);
		end else if (su_exe_valid) begin
			check_value("store register enable", 1, prev_su_r);
			// Commit low at the edge keeps the head back
			check_value("store commit gate", 1, prev_commit);
			check_value("store queue occupied", 1, st_q.size() != 0);
			s = st_q[0];
			check_value("store sources ready", 2'b11, {rdy_snap[s.rs1], rdy_snap[s.rs2]});
		end
	endtask

	// Take accepted packets, then drive the next cycle
	task automatic drive(input logic dispatch_on);
		logic [63:0]       r;
		lsu_pkg::phy_tag_t t;
		lsu_pkg::lu_uop_t  u;
		lsu_pkg::su_uop_t  s;
		int                k;
		logic              new_busy;
		new_busy = 1'b0;
		// Ready high three times in four
		take_bits(2, r);
		lu_exe_ready = r[1] | r[0];
		take_bits(2, r);
		su_exe_ready = r[1] | r[0];
		if (lu_exe_valid && lu_exe_ready) begin
			u = ld_uop[lu_exe.rd];
			k = ld_kind[lu_exe.rd];
			check_value("load address", lsu_pkg::xlen_t'(reg_val[u.rs1] + u.imm), lu_exe.addr);
			// lbu lhu lwu take the width of lb lh lw
			check_value("load width", 4'b1000 >> (k % 4),
				{lu_exe.width_b, lu_exe.width_h, lu_exe.width_w, lu_exe.width_d});
			check_value("load unsigned", k >= 4, lu_exe.is_unsigned);
			ld_pend[lu_exe.rd] = 1'b0;
		end
		if (su_exe_valid && su_exe_ready) begin
			// Queue front is the oldest store
			s = st_q.pop_front();
			k = st_kind_q.pop_front();
			check_value("store address", lsu_pkg::xlen_t'(reg_val[s.rs1] + s.imm), su_exe.addr);
			check_value("store data", reg_val[s.rs2], su_exe.data);
			check_value("store width", 4'b1000 >> k,
				{su_exe.width_b, su_exe.width_h, su_exe.width_w, su_exe.width_d});
		end
		rdy_snap = reg_rdy;
		prev_lu_v = lu_exe_valid;
		prev_lu_r = lu_exe_ready;
		prev_lu = lu_exe;
		prev_su_v = su_exe_valid;
		prev_su_r = su_exe_ready;
		prev_su = su_exe;
		// Toggle now and then for stretches of both levels
		take_bits(3, r);
		if (r[2:0] == 3'd0) begin
			commit_ready = ~commit_ready;
		end
		prev_commit = commit_ready;
		lu_push = 1'b0;
		su_push = 1'b0;
		alloc_valid = 1'b0;
		wb_valid = 1'b0;
		take_bits(2, r);
		if (dispatch_on && r[0] && !r[1] && !lu_full) begin
			take_bits(6, r);
			t = r[5:0];
			// rd must be idle and unnamed by waiting ops
			if (reg_rdy[t] && !tag_in_use(t)) begin
				take_bits(22, r);
				k = r[14:12] % 7;
				u = '0;
				{u.lb, u.lh, u.lw, u.ld, u.lbu, u.lhu, u.lwu} = 7'b1000000 >> k;
				u.imm = {{52{r[11]}}, r[11:0]};
				u.rd = t;
				// Often chained on the previous load
				u.rs1 = r[21] ? last_rd : r[20:15];
				lu_push = 1'b1;
				lu_push_uop = u;
				alloc_valid = 1'b1;
				alloc_tag = t;
				ld_pend[t] = 1'b1;
				ld_uop[t] = u;
				ld_kind[t] = k;
				reg_rdy[t] = 1'b0;
				last_rd = t;
				new_busy = 1'b1;
				dispatched++;
			end
		end else if (dispatch_on && r[0] && r[1] && !su_full) begin
			take_bits(27, r);
			k = r[13:12];
			s = '0;
			{s.sb, s.sh, s.sw, s.sd} = 4'b1000 >> k;
			s.imm = {{52{r[11]}}, r[11:0]};
			s.rs1 = r[19:14];
			s.rs2 = r[26] ? last_rd : r[25:20];
			su_push = 1'b1;
			su_push_uop = s;
			st_q.push_back(s);
			st_kind_q.push_back(k);
			dispatched++;
		end
		// One writeback to a random busy tag, never the one just renamed
		take_bits(1, r);
		if (r[0] && busy_q.size() > 0) begin
			take_bits(6, r);
			k = r[5:0] % busy_q.size();
			wb_tag = busy_q[k];
			busy_q.delete(k);
			take_bits(64, r);
			wb_valid = 1'b1;
			wb_data = r;
			reg_val[wb_tag] = r;
			reg_rdy[wb_tag] = 1'b1;
		end
		if (new_busy) begin
			busy_q.push_back(t);
		end
	endtask

	initial begin
		int drain;
		drain = 0;
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		arst_n = 1'b1;
		check_value("reset load valid", 0, lu_exe_valid);
		check_value("reset store valid", 0, su_exe_valid);
		check_value("reset load full", 0, lu_full);
		check_value("reset store full", 0, su_full);
		while (dispatched < N_OPS) begin
			@(negedge CLK);
			observe();
			drive(1'b1);
		end
		// Dispatch stopped, let everything issue
		while ((ld_pend != '0 || st_q.size() != 0) && drain < DRAIN_MAX) begin
			@(negedge CLK);
			observe();
			drive(1'b0);
			drain++;
		end
		@(negedge CLK);
		observe();
		if (ld_pend != '0 || st_q.size() != 0) begin
			abort_run("Loads or stores were still waiting at the end of the run");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

	// Watchdog
	initial begin
		repeat (LIMIT) @(posedge CLK);
		abort_run("Watchdog expired before all loads and stores issued");
	end

endmodule

// File: design/lsu_issue_top.sv
// Load/store issue stage top
`timescale 1ns/1ps

module lsu_issue_top #(
	parameter int LU_DEPTH = 8,
	parameter int SU_DEPTH = 4
) (
	input  logic              CLK,
	input  logic              arst_n,
	// Dispatch
	input  logic              lu_push,
	input  lsu_pkg::lu_uop_t  lu_push_uop,
	output logic              lu_full,
	input  logic              su_push,
	input  lsu_pkg::su_uop_t  su_push_uop,
	output logic              su_full,
	// Rename allocation and writeback
	input  logic              alloc_valid,
	input  lsu_pkg::phy_tag_t alloc_tag,
	input  logic              wb_valid,
	input  lsu_pkg::phy_tag_t wb_tag,
	input  lsu_pkg::xlen_t    wb_data,
	// Commit
	input  logic              commit_ready,
	// Execution packets
	input  logic              lu_exe_ready,
	output logic              lu_exe_valid,
	output lsu_pkg::lu_exe_t  lu_exe,
	input  logic              su_exe_ready,
	output logic              su_exe_valid,
	output lsu_pkg::su_exe_t  su_exe
);

	logic [LU_DEPTH-1:0]                        lu_slot_valid;
	lsu_pkg::lu_uop_t [LU_DEPTH-1:0]            lu_slot_uop;
	logic                                       lu_pop;
	logic [$clog2(LU_DEPTH)-1:0]                lu_pop_index;
	logic                                       su_empty;
	lsu_pkg::su_uop_t                           su_head_uop;
	logic                                       su_pop;
	logic [lsu_pkg::NUM_PREG-1:0]               wb_log;
	lsu_pkg::xlen_t [lsu_pkg::NUM_PREG-1:0]     reg_value;

	// Out-of-order load slots
	lu_issue_buffer #(.LU_DEPTH(LU_DEPTH)) u_lu_buffer (
		.CLK(CLK), .arst_n(arst_n),
		.lu_push(lu_push), .lu_push_uop(lu_push_uop), .lu_full(lu_full),
		.lu_pop(lu_pop), .lu_pop_index(lu_pop_index),
		.lu_slot_valid(lu_slot_valid), .lu_slot_uop(lu_slot_uop)
	);

	// In-order stores
	su_issue_fifo #(.SU_DEPTH(SU_DEPTH)) u_su_fifo (
		.CLK(CLK), .arst_n(arst_n),
		.su_push(su_push), .su_push_uop(su_push_uop), .su_full(su_full),
		.su_pop(su_pop), .su_empty(su_empty), .su_head_uop(su_head_uop)
	);

	reg_file_wb_log u_reg_file (
		.CLK(CLK), .arst_n(arst_n),
		.alloc_valid(alloc_valid), .alloc_tag(alloc_tag),
		.wb_valid(wb_valid), .wb_tag(wb_tag), .wb_data(wb_data),
		.wb_log(wb_log), .reg_value(reg_value)
	);

	lsu_issue #(.LU_DEPTH(LU_DEPTH)) u_issue (
		.CLK(CLK), .arst_n(arst_n),
		.lu_slot_valid(lu_slot_valid), .lu_slot_uop(lu_slot_uop),
		.lu_pop(lu_pop), .lu_pop_index(lu_pop_index),
		.lu_exe_ready(lu_exe_ready), .lu_exe_valid(lu_exe_valid), .lu_exe(lu_exe),
		.su_empty(su_empty), .su_head_uop(su_head_uop), .su_pop(su_pop),
		.su_exe_ready(su_exe_ready), .su_exe_valid(su_exe_valid), .su_exe(su_exe),
		.commit_ready(commit_ready),
		.wb_log(wb_log), .reg_value(reg_value)
	);

endmodule

// File: design/lsu_issue.sv
// Load and store issue select
`timescale 1ns/1ps

module lsu_issue #(
	parameter int LU_DEPTH = 8
) (
	input  logic                                       CLK,
	input  logic                                       arst_n,
	// Load buffer side, any order
	input  logic [LU_DEPTH-1:0]                        lu_slot_valid,
	input  lsu_pkg::lu_uop_t [LU_DEPTH-1:0]            lu_slot_uop,
	output logic                                       lu_pop,
	output logic [$clog2(LU_DEPTH)-1:0]                lu_pop_index,
	// Load unit
	input  logic                                       lu_exe_ready,
	output logic                                       lu_exe_valid,
	output lsu_pkg::lu_exe_t                           lu_exe,
	// Store FIFO side, program order
	input  logic                                       su_empty,
	input  lsu_pkg::su_uop_t                           su_head_uop,
	output logic                                       su_pop,
	// Store unit
	input  logic                                       su_exe_ready,
	output logic                                       su_exe_valid,
	output lsu_pkg::su_exe_t                           su_exe,
	// Older instructions all retired
	input  logic                                       commit_ready,
	// Register file read
	input  logic [lsu_pkg::NUM_PREG-1:0]               wb_log,
	input  lsu_pkg::xlen_t [lsu_pkg::NUM_PREG-1:0]     reg_value
);

	typedef logic [$clog2(LU_DEPTH)-1:0] slot_idx_t;

	logic [LU_DEPTH-1:0] lu_clear;
	slot_idx_t           lu_sel_index;
	logic                lu_any_clear;
	lsu_pkg::lu_uop_t    lu_sel_uop;
	lsu_pkg::lu_exe_t    lu_exe_nxt;

	logic                su_clear;
	lsu_pkg::su_exe_t    su_exe_nxt;

	// Load side

	// Slot may go once its base register is written back
	always_comb begin
		for (int i = 0; i < LU_DEPTH; i++) begin
			lu_clear[i] = lu_slot_valid[i] & wb_log[lu_slot_uop[i].rs1];
		end
	end

	// Lowest clear slot wins
	always_comb begin
		lu_sel_index = '0;
		lu_any_clear = 1'b0;
		for (int i = LU_DEPTH - 1; i >= 0; i--) begin
			if (lu_clear[i]) begin
				lu_sel_index = slot_idx_t'(i);
				lu_any_clear = 1'b1;
			end
		end
	end

	assign lu_sel_uop = lu_slot_uop[lu_sel_index];

	// Packet build
	// signed and unsigned forms share a width bit
	always_comb begin
		lu_exe_nxt.width_b     = lu_sel_uop.lb | lu_sel_uop.lbu;
		lu_exe_nxt.width_h     = lu_sel_uop.lh | lu_sel_uop.lhu;
		lu_exe_nxt.width_w     = lu_sel_uop.lw | lu_sel_uop.lwu;
		lu_exe_nxt.width_d     = lu_sel_uop.ld;
		lu_exe_nxt.rd          = lu_sel_uop.rd;
		lu_exe_nxt.addr        = reg_value[lu_sel_uop.rs1] + lu_sel_uop.imm;
		lu_exe_nxt.is_unsigned = lu_sel_uop.lbu | lu_sel_uop.lhu | lu_sel_uop.lwu;
	end

	// Release the slot in the cycle its packet is loaded
	assign lu_pop       = lu_exe_ready & lu_any_clear;
	assign lu_pop_index = lu_sel_index;

	// Valid holds while the load unit stalls
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			lu_exe_valid <= 1'b0;
		end else if (lu_exe_ready) begin
			lu_exe_valid <= lu_any_clear;
		end
	end

	always_ff @(posedge CLK) begin
		if (lu_exe_ready) begin
			lu_exe <= lu_exe_nxt;
		end
	end

	// Store side

	// Both sources written and nothing older left to retire
	assign su_clear = ~su_empty
		& wb_log[su_head_uop.rs1]
		& wb_log[su_head_uop.rs2]
		& commit_ready;

	always_comb begin
		su_exe_nxt.width_b = su_head_uop.sb;
		su_exe_nxt.width_h = su_head_uop.sh;
		su_exe_nxt.width_w = su_head_uop.sw;
		su_exe_nxt.width_d = su_head_uop.sd;
		su_exe_nxt.addr    = reg_value[su_head_uop.rs1] + su_head_uop.imm;
		su_exe_nxt.data    = reg_value[su_head_uop.rs2];
	end

	// Head pops together with the packet load
	assign su_pop = su_exe_ready & su_clear;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			su_exe_valid <= 1'b0;
		end else if (su_exe_ready) begin
			su_exe_valid <= su_clear;
		end
	end

	always_ff @(posedge CLK) begin
		if (su_exe_ready) begin
			su_exe <= su_exe_nxt;
		end
	end

endmodule

// File: design/reg_file_wb_log.sv
// Physical register file with writeback log
`timescale 1ns/1ps

module reg_file_wb_log (
	input  logic                                       CLK,
	input  logic                                       arst_n,
	// Destination allocation at dispatch
	input  logic                                       alloc_valid,
	input  lsu_pkg::phy_tag_t                          alloc_tag,
	// Result writeback
	input  logic                                       wb_valid,
	input  lsu_pkg::phy_tag_t                          wb_tag,
	input  lsu_pkg::xlen_t                             wb_data,
	// Read side, whole file visible
	output logic [lsu_pkg::NUM_PREG-1:0]               wb_log,
	output lsu_pkg::xlen_t [lsu_pkg::NUM_PREG-1:0]     reg_value
);

	logic [lsu_pkg::NUM_PREG-1:0] alloc_hit;
	logic [lsu_pkg::NUM_PREG-1:0] wb_hit;
	logic [lsu_pkg::NUM_PREG-1:0] wb_log_nxt;

	// Tag decode
	always_comb begin
		alloc_hit = '0;
		wb_hit    = '0;
		if (alloc_valid) begin
			alloc_hit[alloc_tag] = 1'b1;
		end
		if (wb_valid) begin
			wb_hit[wb_tag] = 1'b1;
		end
	end

	// Ready log update
	// set term applied last so writeback beats allocation
	always_comb begin
		wb_log_nxt = (wb_log & ~alloc_hit) | wb_hit;
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			// All registers start ready
			wb_log <= '1;
		end else begin
			wb_log <= wb_log_nxt;
		end
	end

	// Register values, cleared to zero on reset
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			reg_value <= '0;
		end else begin
			for (int t = 0; t < lsu_pkg::NUM_PREG; t++) begin
				if (wb_hit[t]) begin
					reg_value[t] <= wb_data;
				end
			end
		end
	end

endmodule

// File: design/su_issue_fifo.sv
// Store issue FIFO
`timescale 1ns/1ps

module su_issue_fifo #(
	parameter int SU_DEPTH = 4
) (
	input  logic             CLK,
	input  logic             arst_n,
	// Dispatch side
	input  logic             su_push,
	input  lsu_pkg::su_uop_t su_push_uop,
	output logic             su_full,
	// Head towards issue
	input  logic             su_pop,
	output logic             su_empty,
	output lsu_pkg::su_uop_t su_head_uop
);

	localparam int AW = $clog2(SU_DEPTH);

	// Extra MSB tells a wrapped pointer apart
	typedef logic [AW:0] fifo_ptr_t;

	lsu_pkg::su_uop_t mem [SU_DEPTH];
	fifo_ptr_t        wr_ptr;
	fifo_ptr_t        rd_ptr;
	logic             push_en;
	logic             pop_en;

	assign su_empty = (wr_ptr == rd_ptr);
	// Same address, opposite lap
	assign su_full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	assign push_en = su_push & ~su_full;
	assign pop_en  = su_pop & ~su_empty;

	// Oldest store always presented
	assign su_head_uop = mem[rd_ptr[AW-1:0]];

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// Entry storage
	always_ff @(posedge CLK) begin
		if (push_en) begin
			mem[wr_ptr[AW-1:0]] <= su_push_uop;
		end
	end

endmodule

// File: design/lu_issue_buffer.sv
// Load issue buffer
`timescale 1ns/1ps

module lu_issue_buffer #(
	parameter int LU_DEPTH = 8
) (
	input  logic                                    CLK,
	input  logic                                    arst_n,
	// Dispatch side
	input  logic                                    lu_push,
	input  lsu_pkg::lu_uop_t                        lu_push_uop,
	output logic                                    lu_full,
	// Release from issue
	input  logic                                    lu_pop,
	input  logic [$clog2(LU_DEPTH)-1:0]             lu_pop_index,
	// Slot contents towards issue
	output logic [LU_DEPTH-1:0]                     lu_slot_valid,
	output lsu_pkg::lu_uop_t [LU_DEPTH-1:0]         lu_slot_uop
);

	typedef logic [$clog2(LU_DEPTH)-1:0] slot_idx_t;

	slot_idx_t free_index;
	logic      push_en;

	// Full when every slot holds a load
	assign lu_full = &lu_slot_valid;

	// Pushes into a full buffer are dropped
	assign push_en = lu_push & ~lu_full;

	// Lowest free slot
	// scan runs downward so the last hit is the lowest index
	always_comb begin
		free_index = '0;
		for (int i = LU_DEPTH - 1; i >= 0; i--) begin
			if (!lu_slot_valid[i]) begin
				free_index = slot_idx_t'(i);
			end
		end
	end

	// Allocation bits
	// push targets a free slot and pop an allocated one, so both may hit in one cycle
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			lu_slot_valid <= '0;
		end else begin
			if (push_en) begin
				lu_slot_valid[free_index] <= 1'b1;
			end
			if (lu_pop) begin
				lu_slot_valid[lu_pop_index] <= 1'b0;
			end
		end
	end

	// Slot payload, stays in place until released
	always_ff @(posedge CLK) begin
		if (push_en) begin
			lu_slot_uop[free_index] <= lu_push_uop;
		end
	end

endmodule

// File: design/lsu_pkg.sv
// Load/store issue types
package lsu_pkg;

	// Integer data and address width
	localparam int XLEN = 64;

	// Physical register tag width
	localparam int TAG_W = 6;

	// Physical register count
	localparam int NUM_PREG = 1 << TAG_W;

	typedef logic [XLEN-1:0] xlen_t;
	typedef logic [TAG_W-1:0] phy_tag_t;

	// Load micro-op from dispatch, one-hot opcode bits first
	typedef struct packed {
		logic lb;
		logic lh;
		logic lw;
		logic ld;
		logic lbu;
		logic lhu;
		logic lwu;
		xlen_t imm;
		phy_tag_t rd;
		phy_tag_t rs1;
	} lu_uop_t;

	// Store micro-op from dispatch
	typedef struct packed {
		logic sb;
		logic sh;
		logic sw;
		logic sd;
		xlen_t imm;
		phy_tag_t rs1;
		phy_tag_t rs2;
	} su_uop_t;

	// Load unit packet
	typedef struct packed {
		logic width_b;
		logic width_h;
		logic width_w;
		logic width_d;
		phy_tag_t rd;
		xlen_t addr;
		logic is_unsigned;
	} lu_exe_t;

	// Store unit packet
	typedef struct packed {
		logic width_b;
		logic width_h;
		logic width_w;
		logic width_d;
		xlen_t addr;
		xlen_t data;
	} su_exe_t;

endpackage
